// File: flist.f
ros2_app_pkg.sv
rst_sync.sv
pub_msg_gen.sv
sub_msg_store.sv
ram_1rw.sv
ros2_node_top.sv
tb_ros2_node.sv

// File: Makefile
# Verilator flow for the ROS2 node application testbench

VERILATOR ?= verilator
TOP       ?= tb_ros2_node
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

FAIL_MSG := Finished with errors
PASS_MSG := Finished with no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# The log decides the result, a missing end line counts as a failure
sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failures"; exit 1; \
	fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result line"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_ros2_node.sv
// ******************************
// Testbench for the ROS2 node app
// that plays the protocol engine
// ******************************

`timescale 1ns/1ps

module tb_ros2_node;

    localparam int MSG_INTERVAL  = 20;
    localparam int PAYLOAD_DEPTH = 64;
    localparam int NUM_PUB_MSGS  = 12;
    localparam int MAX_GRANT_DLY = 7;
    localparam int HOLD_CYCLES   = 50;
    // One extra message covers the back-pressure case
    localparam int TIMEOUT_CYCLES =
        (NUM_PUB_MSGS + 1) * (MSG_INTERVAL + HOLD_CYCLES + 10) + 500;

    logic         clk_int;
    logic         rst_n;
    logic         pll_locked;
    logic         pub_grant;
    logic         pub_req;
    logic         pub_rel;
    logic [255:0] pub_app_data;
    logic [7:0]   pub_app_data_len;
    logic [4:0]   sub_addr;
    logic         sub_ce;
    logic         sub_we;
    logic [7:0]   sub_wdata;
    logic         sub_recv;
    logic [4:0]   sub_rd_addr;
    logic [7:0]   sub_rd_data;
    logic [7:0]   sub_msg_count;
    logic [3:0]   led;
    logic         payload_cs;
    logic         payload_we;
    logic [5:0]   payload_addr;
    logic [7:0]   payload_wdata;
    logic [7:0]   payload_rdata;

    int           errors;
    int           errors_mark;
    int           tests_done;
    int           lock_cycles;
    logic [7:0]   exp_digit;
    logic [255:0] exp_msg;
    logic [3:0]   led_expect;
    logic [7:0]   count_expect;
    logic [7:0]   sub_model [32];
    logic [7:0]   pay_model [PAYLOAD_DEPTH];
    logic         rd_check;
    logic         rd_check_q;
    logic [7:0]   rd_expect;
    logic [7:0]   rd_expect_q;
    logic         pay_check;
    logic         pay_check_q;
    logic [7:0]   pay_expect;
    logic [7:0]   pay_expect_q;

    initial clk_int = 1'b0;
    always #50 clk_int = ~clk_int;

    ros2_node_top #(
        .MSG_INTERVAL  (MSG_INTERVAL),
        .PAYLOAD_DEPTH (PAYLOAD_DEPTH)
    ) dut_i (
        .clk_int          (clk_int),
        .rst_n            (rst_n),
        .pll_locked       (pll_locked),
        .pub_grant        (pub_grant),
        .pub_req          (pub_req),
        .pub_rel          (pub_rel),
        .pub_app_data     (pub_app_data),
        .pub_app_data_len (pub_app_data_len),
        .sub_addr         (sub_addr),
        .sub_ce           (sub_ce),
        .sub_we           (sub_we),
        .sub_wdata        (sub_wdata),
        .sub_recv         (sub_recv),
        .sub_rd_addr      (sub_rd_addr),
        .sub_rd_data      (sub_rd_data),
        .sub_msg_count    (sub_msg_count),
        .led              (led),
        .payload_cs       (payload_cs),
        .payload_we       (payload_we),
        .payload_addr     (payload_addr),
        .payload_wdata    (payload_wdata),
        .payload_rdata    (payload_rdata)
    );

    // Expected message image from the byte layout
    function automatic logic [255:0] build_msg(input logic [7:0] digit);
        string        text;
        logic [255:0] msg;
        text = "Message From FPGA - ";
        msg = '0;
        msg[7:0] = 8'd22;
        for (int i = 0; i < text.len(); i++) begin
            msg[(4 + i)*8 +: 8] = text[i];
        end
        msg[24*8 +: 8] = digit;
        return msg;
    endfunction

    function automatic logic [5:0] payload_slot(input int w);
        return 6'((w * 37 + 3) % PAYLOAD_DEPTH);
    endfunction

    task automatic report_mismatch(input string name, input logic [255:0] got,
                                   input logic [255:0] expected);
        $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, expected);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic next_cycle();
        @(posedge clk_int);
        #10;
    endtask

    task automatic wait_req();
        while (!pub_req) begin
            next_cycle();
        end
    endtask

    task automatic grant_after(input int delay);
        repeat (delay) next_cycle();
        pub_grant = 1'b1;
        next_cycle();
        pub_grant = 1'b0;
    endtask

    task automatic write_sub(input logic [4:0] addr, input logic [7:0] data);
        sub_addr  = addr;
        sub_wdata = data;
        sub_ce    = 1'b1;
        sub_we    = 1'b1;
        sub_model[addr] = data;
        next_cycle();
    endtask

    task automatic finish_test(input string name);
        int failed;
        failed = errors - errors_mark;
        $display("test %-12s %0d failed checks", name, failed);
        errors_mark = errors;
        tests_done++;
    endtask

    assign exp_msg = build_msg(exp_digit);

    // Engine-side view of digit, LED nibble and message count
    always @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            exp_digit    <= 8'h30;
            led_expect   <= 4'h0;
            count_expect <= 8'h00;
        end else begin
            if (pub_req && pub_grant) begin
                exp_digit <= (exp_digit == 8'h39) ? 8'h30 : exp_digit + 8'h01;
            end
            if (sub_ce && sub_we && sub_addr == 5'd0) begin
                led_expect <= sub_wdata[3:0];
            end
            if (sub_recv) begin
                count_expect <= count_expect + 8'h01;
            end
        end
    end

    // Edges seen since clock lock
    always @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            lock_cycles <= 0;
        end else if (pll_locked) begin
            lock_cycles <= lock_cycles + 1;
        end
    end

    always @(posedge clk_int) begin
        rd_check_q   <= rd_check;
        rd_expect_q  <= rd_expect;
        pay_check_q  <= pay_check;
        pay_expect_q <= pay_expect;
    end

    a_reset_outputs: assert property (@(posedge clk_int)
        !rst_n |-> (!pub_req && !pub_rel && led == 4'h0 && sub_msg_count == 8'h00))
        else report_failure("outputs not cleared while reset is asserted");

    a_req_early: assert property (@(posedge clk_int) disable iff (!rst_n)
        pub_req |-> lock_cycles >= MSG_INTERVAL + 4)
        else report_failure("pub_req raised too soon after clock lock");

    a_rel_after_grant: assert property (@(posedge clk_int) disable iff (!rst_n)
        pub_req && pub_grant |=> pub_rel && !pub_req)
        else report_failure("pub_rel missing or pub_req still high after grant");

    a_rel_cause: assert property (@(posedge clk_int) disable iff (!rst_n)
        pub_rel |-> $past(pub_req && pub_grant))
        else report_failure("pub_rel without a granted request");

    a_rel_pulse: assert property (@(posedge clk_int) disable iff (!rst_n)
        pub_rel |=> !pub_rel)
        else report_failure("pub_rel held high for more than one cycle");

    a_len: assert property (@(posedge clk_int) disable iff (!rst_n)
        pub_req |-> pub_app_data_len == 8'd26)
        else report_mismatch("pub_app_data_len", 256'($sampled(pub_app_data_len)), 256'd26);

    a_msg_body: assert property (@(posedge clk_int) disable iff (!rst_n)
        pub_req || pub_rel |-> pub_app_data == exp_msg)
        else report_mismatch("pub_app_data", $sampled(pub_app_data), $sampled(exp_msg));

    a_req_hold: assert property (@(posedge clk_int) disable iff (!rst_n)
        pub_req && !pub_grant |=> pub_req)
        else report_failure("pub_req dropped while grant was withheld");

    a_data_hold: assert property (@(posedge clk_int) disable iff (!rst_n)
        pub_req && !pub_grant |=> $stable(pub_app_data))
        else report_failure("pub_app_data changed while grant was withheld");

    a_sub_read: assert property (@(posedge clk_int) disable iff (!rst_n)
        rd_check_q |-> sub_rd_data == rd_expect_q)
        else report_mismatch("sub_rd_data", 256'($sampled(sub_rd_data)),
                             256'($sampled(rd_expect_q)));

    a_led: assert property (@(posedge clk_int) disable iff (!rst_n)
        led == led_expect)
        else report_mismatch("led", 256'($sampled(led)), 256'($sampled(led_expect)));

    a_count: assert property (@(posedge clk_int) disable iff (!rst_n)
        sub_msg_count == count_expect)
        else report_mismatch("sub_msg_count", 256'($sampled(sub_msg_count)),
                             256'($sampled(count_expect)));

    a_pay_read: assert property (@(posedge clk_int) disable iff (!rst_n)
        pay_check_q |-> payload_rdata == pay_expect_q)
        else report_mismatch("payload_rdata", 256'($sampled(payload_rdata)),
                             256'($sampled(pay_expect_q)));

    a_pay_write_hold: assert property (@(posedge clk_int) disable iff (!rst_n)
        payload_cs && payload_we |=> $stable(payload_rdata))
        else report_failure("payload_rdata changed on a write");

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_int);
        $display("timeout: run did not complete in %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        void'($urandom(32'h4a66));
        errors        = 0;
        errors_mark   = 0;
        tests_done    = 0;
        rst_n         = 1'b1;
        pll_locked    = 1'b0;
        pub_grant     = 1'b0;
        sub_addr      = 5'd0;
        sub_ce        = 1'b0;
        sub_we        = 1'b0;
        sub_wdata     = 8'h00;
        sub_recv      = 1'b0;
        sub_rd_addr   = 5'd0;
        payload_cs    = 1'b0;
        payload_we    = 1'b0;
        payload_addr  = 6'd0;
        payload_wdata = 8'h00;
        rd_check      = 1'b0;
        rd_expect     = 8'h00;
        pay_check     = 1'b0;
        pay_expect    = 8'h00;

        #5;
        rst_n = 1'b0;
        repeat (4) next_cycle();
        rst_n = 1'b1;
        repeat (2) next_cycle();
        pll_locked = 1'b1;
        wait_req();
        finish_test("reset");

        for (int m = 0; m < NUM_PUB_MSGS; m++) begin
            wait_req();
            grant_after(int'($urandom % (MAX_GRANT_DLY + 1)));
        end
        finish_test("publish");

        wait_req();
        grant_after(HOLD_CYCLES);
        finish_test("backpressure");

        for (int a = 0; a < 32; a++) begin
            write_sub(5'(a), 8'($urandom));
        end
        // Rewrite byte 0 so the LEDs follow the latest value
        write_sub(5'd0, 8'($urandom));
        sub_ce = 1'b0;
        sub_we = 1'b0;
        for (int a = 0; a < 32; a++) begin
            sub_rd_addr = 5'(a);
            rd_expect   = sub_model[a];
            rd_check    = 1'b1;
            next_cycle();
        end
        rd_check = 1'b0;
        repeat (2) next_cycle();
        finish_test("sub_store");

        repeat (5) begin
            sub_recv = 1'b1;
            next_cycle();
            sub_recv = 1'b0;
            repeat (2) next_cycle();
        end
        finish_test("msg_count");

        payload_cs = 1'b1;
        payload_we = 1'b1;
        for (int w = 0; w < 16; w++) begin
            payload_addr  = payload_slot(w);
            payload_wdata = 8'($urandom);
            pay_model[payload_slot(w)] = payload_wdata;
            next_cycle();
        end
        payload_we = 1'b0;
        for (int w = 0; w < 16; w++) begin
            payload_addr = payload_slot(w);
            pay_expect   = pay_model[payload_slot(w)];
            pay_check    = 1'b1;
            next_cycle();
        end
        payload_cs = 1'b0;
        pay_check  = 1'b0;
        repeat (2) next_cycle();
        finish_test("payload");

        $display("summary: %0d tests run, %0d failed checks", tests_done, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: ros2_node_top.sv
// ******************************
// ROS2 node application top, ties
// reset, pub, sub and payload RAM
// ******************************

`timescale 1ns/1ps

module ros2_node_top #(
    parameter int unsigned MSG_INTERVAL  = 2**27,
    parameter int          PAYLOAD_DEPTH = 2048
) (
    input  logic                                        clk_int,
    input  logic                                        rst_n,
    input  logic                                        pll_locked,

    // Publisher buffer, engine side
    input  logic                                        pub_grant,
    output logic                                        pub_req,
    output logic                                        pub_rel,
    output logic [ros2_app_pkg::MAX_APP_DATA_LEN*8-1:0] pub_app_data,
    output logic [7:0]                                  pub_app_data_len,

    // Subscriber write port and readback
    input  logic [ros2_app_pkg::APP_ADDR_W-1:0]         sub_addr,
    input  logic                                        sub_ce,
    input  logic                                        sub_we,
    input  logic [7:0]                                  sub_wdata,
    input  logic                                        sub_recv,
    input  logic [ros2_app_pkg::APP_ADDR_W-1:0]         sub_rd_addr,
    output logic [7:0]                                  sub_rd_data,
    output logic [7:0]                                  sub_msg_count,
    output logic [3:0]                                  led,

    // IP payload memory
    input  logic                                        payload_cs,
    input  logic                                        payload_we,
    input  logic [$clog2(PAYLOAD_DEPTH)-1:0]            payload_addr,
    input  logic [ros2_app_pkg::PAYLOAD_DWIDTH-1:0]     payload_wdata,
    output logic [ros2_app_pkg::PAYLOAD_DWIDTH-1:0]     payload_rdata
);

    import ros2_app_pkg::*;

    logic rst_n_int;
    logic payload_cs_n;
    logic payload_we_n;

    rst_sync rst_sync_i (
        .clk_int   (clk_int),
        .rst_n     (rst_n),
        .locked    (pll_locked),
        .rst_n_int (rst_n_int)
    );

    pub_msg_gen #(
        .MSG_INTERVAL (MSG_INTERVAL)
    ) pub_msg_gen_i (
        .clk_int      (clk_int),
        .rst_n        (rst_n_int),
        .grant        (pub_grant),
        .req          (pub_req),
        .rel          (pub_rel),
        .app_data     (pub_app_data),
        .app_data_len (pub_app_data_len)
    );

    sub_msg_store sub_msg_store_i (
        .clk_int   (clk_int),
        .rst_n     (rst_n_int),
        .addr      (sub_addr),
        .ce        (sub_ce),
        .we        (sub_we),
        .wdata     (sub_wdata),
        .recv      (sub_recv),
        .rd_addr   (sub_rd_addr),
        .rd_data   (sub_rd_data),
        .led       (led),
        .msg_count (sub_msg_count)
    );

    // RAM controls are active low
    assign payload_cs_n = ~payload_cs;
    assign payload_we_n = ~payload_we;

    ram_1rw #(
        .DEPTH  (PAYLOAD_DEPTH),
        .DWIDTH (PAYLOAD_DWIDTH)
    ) payload_mem_i (
        .clk_int (clk_int),
        .rst_n   (rst_n_int),
        .cs_n    (payload_cs_n),
        .we_n    (payload_we_n),
        .addr    (payload_addr),
        .wdata   (payload_wdata),
        .rdata   (payload_rdata)
    );

endmodule

// File: ram_1rw.sv
// ******************************
// Single-port synchronous RAM
// ******************************

`timescale 1ns/1ps

module ram_1rw #(
    parameter int DEPTH  = 2048,
    parameter int DWIDTH = 8
) (
    input  logic                     clk_int,
    input  logic                     rst_n,
    input  logic                     cs_n,
    input  logic                     we_n,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [DWIDTH-1:0]        wdata,
    output logic [DWIDTH-1:0]        rdata
);

    logic [DWIDTH-1:0] mem [0:DEPTH-1];

    always_ff @(posedge clk_int) begin
        if (!cs_n && !we_n) begin
            mem[addr] <= wdata;
        end
    end

    // Read register, held across writes
    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (!cs_n && we_n) begin
            rdata <= mem[addr];
        end
    end

    a_addr_range: assert property (
        @(posedge clk_int) disable iff (!rst_n)
        !cs_n |-> (int'(addr) < DEPTH)
    ) else $error("ram_1rw address out of range");

endmodule

// File: sub_msg_store.sv
// ******************************
// Subscriber message store with
// LED nibble and message counter
// ******************************

`timescale 1ns/1ps

module sub_msg_store (
    input  logic                              clk_int,
    input  logic                              rst_n,
    input  logic [ros2_app_pkg::APP_ADDR_W-1:0] addr,
    input  logic                              ce,
    input  logic                              we,
    input  logic [7:0]                        wdata,
    input  logic                              recv,
    input  logic [ros2_app_pkg::APP_ADDR_W-1:0] rd_addr,
    output logic [7:0]                        rd_data,
    output logic [3:0]                        led,
    output logic [7:0]                        msg_count
);

    import ros2_app_pkg::*;

    logic [7:0] msg_mem [0:MAX_APP_DATA_LEN-1];
    logic       wr_en;

    assign wr_en = ce && we;

    always_ff @(posedge clk_int) begin
        if (wr_en) begin
            msg_mem[addr] <= wdata;
        end
        rd_data <= msg_mem[rd_addr];
    end

    // Shadow of byte 0 low nibble for the LEDs
    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            led <= 4'h0;
        end else if (wr_en && addr == '0) begin
            led <= wdata[3:0];
        end
    end

    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            msg_count <= 8'd0;
        end else if (recv) begin
            msg_count <= msg_count + 8'd1;
        end
    end

    // Engine finishes its writes before flagging the message
    a_ce_recv_excl: assert property (
        @(posedge clk_int) disable iff (!rst_n)
        !(ce && recv)
    ) else $error("sub ce and recv high together");

endmodule

// File: pub_msg_gen.sv
// ******************************
// Publisher message source, paces
// requests and runs req/grant/rel
// ******************************

`timescale 1ns/1ps

module pub_msg_gen #(
    parameter int unsigned MSG_INTERVAL = 2**27
) (
    input  logic                                      clk_int,
    input  logic                                      rst_n,
    input  logic                                      grant,
    output logic                                      req,
    output logic                                      rel,
    output logic [ros2_app_pkg::MAX_APP_DATA_LEN*8-1:0] app_data,
    output logic [7:0]                                app_data_len
);

    import ros2_app_pkg::*;

    localparam int CNT_W = $clog2(MSG_INTERVAL + 1);

    logic [CNT_W-1:0] interval_cnt;
    logic [7:0]       digit;

    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            interval_cnt <= '0;
            req          <= 1'b0;
            rel          <= 1'b0;
            digit        <= DIGIT_FIRST;
        end else begin
            rel <= 1'b0;
            if (req) begin
                // Waiting on the engine, counter parked at zero
                interval_cnt <= '0;
                if (grant) begin
                    req   <= 1'b0;
                    rel   <= 1'b1;
                    digit <= (digit == DIGIT_LAST) ? DIGIT_FIRST : digit + 8'd1;
                end
            end else if (interval_cnt == CNT_W'(MSG_INTERVAL - 1)) begin
                interval_cnt <= '0;
                req          <= 1'b1;
            end else begin
                interval_cnt <= interval_cnt + 1'b1;
            end
        end
    end

    // Message image: length word, text, digit, zero fill
    always_comb begin
        app_data = '0;
        app_data[7:0] = PUB_STR_LEN;
        for (int i = 0; i < PUB_TEXT_LEN; i++) begin
            app_data[(PUB_TEXT_OFS + i)*8 +: 8] = PUB_TEXT[(PUB_TEXT_LEN - 1 - i)*8 +: 8];
        end
        app_data[PUB_DIGIT_OFS*8 +: 8] = digit;
    end

    assign app_data_len = PUB_APP_DATA_LEN;

    // Engine must see req held until it grants
    a_req_held: assert property (
        @(posedge clk_int) disable iff (!rst_n)
        req && !grant |=> req
    ) else $error("pub req dropped before grant");

    a_rel_single: assert property (
        @(posedge clk_int) disable iff (!rst_n)
        rel |=> !rel
    ) else $error("pub rel longer than one cycle");

    // Buffer contents frozen while the engine may be copying them
    a_data_stable: assert property (
        @(posedge clk_int) disable iff (!rst_n)
        req && !grant |=> $stable(app_data)
    ) else $error("pub app_data changed while req high");

endmodule

// File: rst_sync.sv
// ******************************
// Reset synchronizer, releases the
// internal reset after clock lock
// ******************************

`timescale 1ns/1ps

module rst_sync (
    input  logic clk_int,
    input  logic rst_n,
    input  logic locked,
    output logic rst_n_int
);

    logic [3:0] sync_q;

    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[2:0], locked};
        end
    end

    // Lock is assumed to stay up once reached
    assign rst_n_int = sync_q[3];

endmodule

// File: ros2_app_pkg.sv
// ******************************
// ROS2 application constants, buffer
// sizes and published message layout
// ******************************

package ros2_app_pkg;

    // Application message buffer
    localparam int MAX_APP_DATA_LEN = 32;
    localparam int APP_ADDR_W       = 5;

    // Published string message, CDR string with 4-byte length
    localparam logic [7:0] PUB_STR_LEN      = 8'd22;
    localparam logic [7:0] PUB_APP_DATA_LEN = PUB_STR_LEN + 8'd4;

    // Rolling digit range, '0' to '9'
    localparam logic [7:0] DIGIT_FIRST = 8'd48;
    localparam logic [7:0] DIGIT_LAST  = 8'd57;

    // Fixed text, first character sits in the top byte of the literal
    localparam int PUB_TEXT_LEN = 20;
    localparam logic [PUB_TEXT_LEN*8-1:0] PUB_TEXT = "Message From FPGA - ";

    // Byte offsets inside the published message
    localparam int PUB_TEXT_OFS  = 4;
    localparam int PUB_DIGIT_OFS = PUB_TEXT_OFS + PUB_TEXT_LEN;

    // IP payload memory word width
    localparam int PAYLOAD_DWIDTH = 8;

endpackage
